// ==== design/daq_settings.svh ====
`ifndef DAQ_SETTINGS_SVH
`define DAQ_SETTINGS_SVH

// ------------------------------
// mcu register map
// ------------------------------
`define ADDR_VERSION     9'h000  // read only
`define ADDR_SAMPLE_DIV  9'h002  // sample interval in clocks
`define ADDR_PHASE_L     9'h00A  // key-phase period, low half
`define ADDR_PHASE_H     9'h00C  // key-phase period, high half
`define ADDR_AD_ENABLE   9'h00E  // rising edge arms capture
`define ADDR_AD_RESET    9'h010  // level to adc reset pin
`define ADDR_CH0_DATA    9'h016  // channel fifos, stride 2
`define ADDR_CH1_DATA    9'h018
`define ADDR_CH2_DATA    9'h01A
`define ADDR_CH3_DATA    9'h01C
`define ADDR_STATUS      9'h036  // bit1 detect_error, bit0 data_full

`define VERSION_WORD     16'h1000

// ------------------------------
// widths and depths
// ------------------------------
`define ADDR_W           9
`define DATA_W           16
`define NUM_CH           4
`define FIFO_DEPTH       16
`define FIFO_AW          4       // log2 of depth

// sequencer timing, in AD_CLK_40M cycles
`define MIN_INTERVAL     64      // floor on sample_div
`define CONVST_CYCLES    2
`define RD_LOW_CYCLES    2
`define RD_HIGH_CYCLES   2

`endif

// ==== design/daq_pkg.sv ====
`include "daq_settings.svh"

package daq_pkg;

    // key-phase period, seen whole by the meter and as halves by the bus
    typedef union packed {
        logic [2*`DATA_W-1:0] count;     // raw cycle count
        struct packed {
            logic [`DATA_W-1:0] hi;      // served at ADDR_PHASE_H
            logic [`DATA_W-1:0] lo;      // served at ADDR_PHASE_L
        } half;
    } phase_period_u;

endpackage

// ==== design/acq_ctrl_if.sv ====
`timescale 1ns/1ns
`include "daq_settings.svh"

interface acq_ctrl_if import daq_pkg::*; ();

    logic [`DATA_W-1:0] sample_div;      // raw interval from mcu
    logic               ad_enable;       // enable bit, level
    logic               ad_reset;        // adc reset bit, level
    logic               arm_clr;         // one-cycle arm pulse
    logic               data_full;       // all channel fifos full
    logic               detect_error;    // no full phase period yet
    phase_period_u      phase_period;

    modport reg_mp   (output sample_div, ad_enable, ad_reset,
                      input  phase_period, detect_error, data_full);

    modport trig_mp  (input  sample_div, ad_enable, data_full,
                      output arm_clr);

    modport fifo_mp  (input  arm_clr,
                      output data_full);

    modport phase_mp (output phase_period, detect_error);

endinterface

// ==== design/mcu_reg_bank.sv ====
`timescale 1ns/1ns
`include "daq_settings.svh"

module mcu_reg_bank import daq_pkg::*; (
    input  logic                AD_CLK_40M,
    input  logic                rst_n_i,
    input  logic                mcu_cs_n_i,
    input  logic                mcu_we_n_i,
    input  logic                mcu_rd_n_i,
    input  logic [`ADDR_W-1:0]  mcu_addr_i,
    input  logic [`DATA_W-1:0]  mcu_data_i,
    input  logic [`DATA_W-1:0]  head_data_i [`NUM_CH],
    input  logic [`NUM_CH-1:0]  empty_i,
    output logic [`DATA_W-1:0]  mcu_data_o,
    output logic                mcu_data_oe_o,
    output logic [`NUM_CH-1:0]  pop_o,
    acq_ctrl_if.reg_mp          ctrl
);

    logic [1:0]         cs_s, we_s, rd_s;    // two-flop strobe sync
    logic [`ADDR_W-1:0] addr_m, addr_s;      // address sync stages
    logic               rd_d;                // rd one more stage, for edge
    logic               rd_fall;
    logic [`NUM_CH-1:0] ch_hit;              // addr on a channel register
    logic [`DATA_W-1:0] rd_hold;             // popped fifo word
    logic [`DATA_W-1:0] rdata;
    phase_period_u      phase_snap;          // frozen while a read is on

    // ------------------------------
    // bus synchroniser
    // ------------------------------
    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cs_s   <= 2'b11;
            we_s   <= 2'b11;
            rd_s   <= 2'b11;
            rd_d   <= 1'b1;
            addr_m <= '0;
            addr_s <= '0;
        end else begin
            cs_s   <= {cs_s[0], mcu_cs_n_i};
            we_s   <= {we_s[0], mcu_we_n_i};
            rd_s   <= {rd_s[0], mcu_rd_n_i};
            rd_d   <= rd_s[1];
            addr_m <= mcu_addr_i;
            addr_s <= addr_m;
        end
    end

    // ------------------------------
    // register writes
    // ------------------------------
    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl.sample_div <= '0;
            ctrl.ad_enable  <= 1'b0;
            ctrl.ad_reset   <= 1'b0;
        end else if (!cs_s[1] && !we_s[1]) begin   // data held stable by master
            case (addr_s)
                `ADDR_SAMPLE_DIV: ctrl.sample_div <= mcu_data_i;
                `ADDR_AD_ENABLE:  ctrl.ad_enable  <= mcu_data_i[0];
                `ADDR_AD_RESET:   ctrl.ad_reset   <= mcu_data_i[0];
                default: ;                         // read-only or unmapped
            endcase
        end
    end

    // ------------------------------
    // fifo pop on rd falling edge
    // ------------------------------
    assign rd_fall = rd_d && !rd_s[1] && !cs_s[1];

    always_comb begin
        for (int i = 0; i < `NUM_CH; i++) begin
            ch_hit[i] = (addr_s == `ADDR_W'(`ADDR_CH0_DATA + 2 * i));
            pop_o[i]  = rd_fall && ch_hit[i] && !empty_i[i];  // empty pops nothing
        end
    end

    always_ff @(posedge AD_CLK_40M) begin
        if (rd_fall) begin
            rd_hold <= '0;                         // empty fifo reads 0
            for (int i = 0; i < `NUM_CH; i++) begin
                if (ch_hit[i] && !empty_i[i]) rd_hold <= head_data_i[i];
            end
        end
    end

    always_ff @(posedge AD_CLK_40M) begin
        if (!mcu_data_oe_o) phase_snap <= ctrl.phase_period;  // both halves coherent
    end

    // ------------------------------
    // read mux and output enable
    // ------------------------------
    always_comb begin
        case (addr_s)
            `ADDR_VERSION:    rdata = `VERSION_WORD;
            `ADDR_SAMPLE_DIV: rdata = ctrl.sample_div;
            `ADDR_PHASE_L:    rdata = phase_snap.half.lo;
            `ADDR_PHASE_H:    rdata = phase_snap.half.hi;
            `ADDR_AD_ENABLE:  rdata = {{(`DATA_W-1){1'b0}}, ctrl.ad_enable};
            `ADDR_AD_RESET:   rdata = {{(`DATA_W-1){1'b0}}, ctrl.ad_reset};
            `ADDR_STATUS:     rdata = {{(`DATA_W-2){1'b0}}, ctrl.detect_error, ctrl.data_full};
            default:          rdata = (|ch_hit) ? rd_hold : '0;
        endcase
    end

    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) mcu_data_oe_o <= 1'b0;
        else          mcu_data_oe_o <= !cs_s[1] && !rd_s[1];
    end

    assign mcu_data_o = mcu_data_oe_o ? rdata : '0;   // quiet bus when not driving

endmodule

// ==== design/phase_meter.sv ====
`timescale 1ns/1ns

module phase_meter import daq_pkg::*; (
    input  logic          AD_CLK_40M,
    input  logic          rst_n_i,
    input  logic          phase_in_i,
    acq_ctrl_if.phase_mp  ctrl
);

    logic [2:0]    ph_s;          // sync pair plus edge stage
    logic          ph_rise;
    logic          seen_one;      // first edge seen, count running
    logic [31:0]   cnt_q;         // cycles since last edge
    phase_period_u period_q;

    assign ph_rise = ph_s[1] && !ph_s[2];

    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ph_s              <= '0;
            seen_one          <= 1'b0;
            cnt_q             <= '0;
            period_q          <= '0;
            ctrl.detect_error <= 1'b1;    // no period yet
        end else begin
            ph_s <= {ph_s[1:0], phase_in_i};
            if (ph_rise) begin
                cnt_q    <= '0;
                seen_one <= 1'b1;
                if (seen_one) begin       // second edge onward
                    period_q.count    <= cnt_q + 32'd1;
                    ctrl.detect_error <= 1'b0;
                end
            end else if (seen_one) begin
                cnt_q <= cnt_q + 32'd1;
            end
        end
    end

    assign ctrl.phase_period = period_q;

endmodule

// ==== design/sample_trigger.sv ====
`timescale 1ns/1ns
`include "daq_settings.svh"

module sample_trigger (
    input  logic         AD_CLK_40M,
    input  logic         rst_n_i,
    acq_ctrl_if.trig_mp  ctrl,
    output logic         start_o
);

    logic               en_d;        // enable one cycle late
    logic               armed;
    logic [`DATA_W-1:0] interval;    // clamped sample_div
    logic [`DATA_W-1:0] tick_cnt;

    assign ctrl.arm_clr = ctrl.ad_enable && !en_d;   // rising edge of enable

    assign interval = (ctrl.sample_div < `DATA_W'(`MIN_INTERVAL)) ?
                      `DATA_W'(`MIN_INTERVAL) : ctrl.sample_div;

    // ------------------------------
    // arm state
    // ------------------------------
    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_d  <= 1'b0;
            armed <= 1'b0;
        end else begin
            en_d <= ctrl.ad_enable;
            if (ctrl.arm_clr)                            armed <= 1'b1;  // wins over stale full
            else if (ctrl.data_full || !ctrl.ad_enable)  armed <= 1'b0;
        end
    end

    // ------------------------------
    // periodic start
    // ------------------------------
    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tick_cnt <= '0;
            start_o  <= 1'b0;
        end else if (!armed || ctrl.arm_clr) begin
            tick_cnt <= '0;
            start_o  <= 1'b0;
        end else if (tick_cnt >= interval - 1'b1) begin
            tick_cnt <= '0;
            start_o  <= 1'b1;                            // one pulse per interval
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            start_o  <= 1'b0;
        end
    end

endmodule

// ==== design/ad7606_seq.sv ====
`timescale 1ns/1ns
`include "daq_settings.svh"

module ad7606_seq (
    input  logic                        AD_CLK_40M,
    input  logic                        rst_n_i,
    input  logic                        start_i,
    input  logic [`DATA_W-1:0]          adc_db_i,
    input  logic                        adc_busy_i,
    output logic                        adc_convst_o,
    output logic                        adc_cs_n_o,
    output logic                        adc_rd_n_o,
    output logic                        sample_valid_o,
    output logic [$clog2(`NUM_CH)-1:0]  sample_ch_o,
    output logic [`DATA_W-1:0]          sample_data_o
);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_CONV    = 3'd1;   // convst low
    localparam logic [2:0] S_BUSY_HI = 3'd2;   // wait busy rise
    localparam logic [2:0] S_BUSY_LO = 3'd3;   // wait busy fall
    localparam logic [2:0] S_RD_LO   = 3'd4;   // cs/rd low
    localparam logic [2:0] S_RD_HI   = 3'd5;   // gap between reads

    logic [2:0] state_q;
    logic [3:0] pw_cnt;      // pulse width counter
    logic       busy_q;      // retimed busy
    logic       rd_last;     // last low cycle of a read

    assign rd_last = (state_q == S_RD_LO) && (pw_cnt == 4'(`RD_LOW_CYCLES - 1));

    always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q        <= S_IDLE;
            pw_cnt         <= '0;
            busy_q         <= 1'b0;
            adc_convst_o   <= 1'b1;
            adc_cs_n_o     <= 1'b1;
            adc_rd_n_o     <= 1'b1;
            sample_valid_o <= 1'b0;
            sample_ch_o    <= '0;
        end else begin
            busy_q         <= adc_busy_i;
            sample_valid_o <= rd_last;        // data lands one cycle after capture
            pw_cnt         <= pw_cnt + 1'b1;
            case (state_q)
                S_IDLE: if (start_i) begin    // starts while busy fall through here
                    adc_convst_o <= 1'b0;
                    pw_cnt       <= '0;
                    state_q      <= S_CONV;
                end
                S_CONV: if (pw_cnt == 4'(`CONVST_CYCLES - 1)) begin
                    adc_convst_o <= 1'b1;
                    state_q      <= S_BUSY_HI;
                end
                S_BUSY_HI: if (busy_q) state_q <= S_BUSY_LO;
                S_BUSY_LO: if (!busy_q) begin
                    adc_cs_n_o  <= 1'b0;
                    adc_rd_n_o  <= 1'b0;
                    pw_cnt      <= '0;
                    sample_ch_o <= '0;
                    state_q     <= S_RD_LO;
                end
                S_RD_LO: if (rd_last) begin
                    adc_cs_n_o <= 1'b1;
                    adc_rd_n_o <= 1'b1;
                    pw_cnt     <= '0;
                    state_q    <= S_RD_HI;
                end
                S_RD_HI: if (pw_cnt == 4'(`RD_HIGH_CYCLES - 1)) begin
                    if (sample_ch_o == $clog2(`NUM_CH)'(`NUM_CH - 1)) begin
                        state_q <= S_IDLE;    // all channels read
                    end else begin
                        sample_ch_o <= sample_ch_o + 1'b1;
                        adc_cs_n_o  <= 1'b0;
                        adc_rd_n_o  <= 1'b0;
                        pw_cnt      <= '0;
                        state_q     <= S_RD_LO;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge AD_CLK_40M) begin
        if (rd_last) sample_data_o <= adc_db_i;   // bus valid on last low cycle
    end

endmodule

// ==== design/sample_fifo_bank.sv ====
`timescale 1ns/1ns
`include "daq_settings.svh"

module sample_fifo_bank (
    input  logic                        AD_CLK_40M,
    input  logic                        rst_n_i,
    input  logic                        sample_valid_i,
    input  logic [$clog2(`NUM_CH)-1:0]  sample_ch_i,
    input  logic [`DATA_W-1:0]          sample_data_i,
    input  logic [`NUM_CH-1:0]          pop_i,
    output logic [`DATA_W-1:0]          head_data_o [`NUM_CH],
    output logic [`NUM_CH-1:0]          empty_o,
    acq_ctrl_if.fifo_mp                 ctrl
);

    localparam int CW  = `FIFO_AW + 1;        // count reaches depth
    localparam int CHW = $clog2(`NUM_CH);

    logic [`NUM_CH-1:0] full;

    for (genvar i = 0; i < `NUM_CH; i++) begin : g_ch
        logic [`DATA_W-1:0]  mem [`FIFO_DEPTH];
        logic [`FIFO_AW-1:0] wr_ptr, rd_ptr;
        logic [CW-1:0]       count;
        logic                wr_en, rd_en;

        assign wr_en = sample_valid_i && (sample_ch_i == CHW'(i)) && !full[i];  // full drops
        assign rd_en = pop_i[i] && !empty_o[i];

        always_ff @(posedge AD_CLK_40M or negedge rst_n_i) begin
            if (!rst_n_i) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else if (ctrl.arm_clr) begin  // arming empties the fifo
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
                if (rd_en) rd_ptr <= rd_ptr + 1'b1;
                count <= count + CW'(wr_en) - CW'(rd_en);
            end
        end

        always_ff @(posedge AD_CLK_40M) begin
            if (wr_en) mem[wr_ptr] <= sample_data_i;
        end

        assign head_data_o[i] = mem[rd_ptr];          // fall-through head
        assign empty_o[i]     = (count == '0);
        assign full[i]        = (count == CW'(`FIFO_DEPTH));
    end

    assign ctrl.data_full = &full;

endmodule

// ==== design/daq_top.sv ====
`timescale 1ns/1ns
`include "daq_settings.svh"

module daq_top (
    input  logic                AD_CLK_40M,
    input  logic                rst_n_i,
    // mcu bus
    input  logic                mcu_cs_n_i,
    input  logic                mcu_we_n_i,
    input  logic                mcu_rd_n_i,
    input  logic [`ADDR_W-1:0]  mcu_addr_i,
    input  logic [`DATA_W-1:0]  mcu_data_i,
    output logic [`DATA_W-1:0]  mcu_data_o,
    output logic                mcu_data_oe_o,   // external tristate control
    // adc
    input  logic [`DATA_W-1:0]  adc_db_i,
    input  logic                adc_busy_i,
    output logic                adc_convst_o,
    output logic                adc_cs_n_o,
    output logic                adc_rd_n_o,
    output logic                adc_reset_o,
    // key phase
    input  logic                phase_in_i
);

    logic                       start;
    logic                       sample_valid;
    logic [$clog2(`NUM_CH)-1:0] sample_ch;
    logic [`DATA_W-1:0]         sample_data;
    logic [`NUM_CH-1:0]         pop;
    logic [`DATA_W-1:0]         head_data [`NUM_CH];
    logic [`NUM_CH-1:0]         empty;

    acq_ctrl_if ctrl_if ();

    mcu_reg_bank u_reg_bank (
        .AD_CLK_40M    (AD_CLK_40M),
        .rst_n_i       (rst_n_i),
        .mcu_cs_n_i    (mcu_cs_n_i),
        .mcu_we_n_i    (mcu_we_n_i),
        .mcu_rd_n_i    (mcu_rd_n_i),
        .mcu_addr_i    (mcu_addr_i),
        .mcu_data_i    (mcu_data_i),
        .head_data_i   (head_data),
        .empty_i       (empty),
        .mcu_data_o    (mcu_data_o),
        .mcu_data_oe_o (mcu_data_oe_o),
        .pop_o         (pop),
        .ctrl          (ctrl_if.reg_mp)
    );

    phase_meter u_phase_meter (
        .AD_CLK_40M (AD_CLK_40M),
        .rst_n_i    (rst_n_i),
        .phase_in_i (phase_in_i),
        .ctrl       (ctrl_if.phase_mp)
    );

    sample_trigger u_trigger (
        .AD_CLK_40M (AD_CLK_40M),
        .rst_n_i    (rst_n_i),
        .ctrl       (ctrl_if.trig_mp),
        .start_o    (start)
    );

    ad7606_seq u_seq (
        .AD_CLK_40M     (AD_CLK_40M),
        .rst_n_i        (rst_n_i),
        .start_i        (start),
        .adc_db_i       (adc_db_i),
        .adc_busy_i     (adc_busy_i),
        .adc_convst_o   (adc_convst_o),
        .adc_cs_n_o     (adc_cs_n_o),
        .adc_rd_n_o     (adc_rd_n_o),
        .sample_valid_o (sample_valid),
        .sample_ch_o    (sample_ch),
        .sample_data_o  (sample_data)
    );

    sample_fifo_bank u_fifos (
        .AD_CLK_40M     (AD_CLK_40M),
        .rst_n_i        (rst_n_i),
        .sample_valid_i (sample_valid),
        .sample_ch_i    (sample_ch),
        .sample_data_i  (sample_data),
        .pop_i          (pop),
        .head_data_o    (head_data),
        .empty_o        (empty),
        .ctrl           (ctrl_if.fifo_mp)
    );

    assign adc_reset_o = ctrl_if.ad_reset;   // register bit straight to pin

endmodule

// ==== verification/tb_adc_model.sv ====
`timescale 1ns/1ns
`include "daq_settings.svh"

module tb_adc_model #(
    parameter int SEED = 32'h5ab1_5c2a
) (
    input  logic               clk_i,
    input  logic               convst_i,
    input  logic               cs_n_i,
    input  logic               rd_n_i,
    output logic               busy_o,
    output logic [`DATA_W-1:0] db_o
);

    logic [`DATA_W-1:0] exp_q [`NUM_CH][$];   // image of each channel fifo
    int                 seed = SEED;
    int                 rd_idx = 0;           // channel of the next read
    int                 conv_cnt = 0;         // conversions fully read out
    logic               convst_prev = 1'b1;
    logic               rd_prev = 1'b1;

    initial begin
        busy_o = 1'b0;
        db_o   = '0;
    end

    // ------------------------------
    // conversion and readout
    // ------------------------------
    // inputs are seen as they were just before the edge, outputs move 1 ns later
    always @(posedge clk_i) begin : adc_proc
        int                 busy_len;
        logic [`DATA_W-1:0] word;
        if (convst_i && !convst_prev) begin                       // convst rising starts it
            busy_len = 5 + $unsigned($random(seed)) % 16;         // 5 to 20 cycles
            rd_idx   = 0;
            #1 busy_o = 1'b1;
            repeat (busy_len) @(posedge clk_i);
            #1 busy_o = 1'b0;
        end else if (!cs_n_i && !rd_n_i && rd_prev && rd_idx < `NUM_CH) begin
            word = $random(seed);                                 // fresh word per read
            if (exp_q[rd_idx].size() < `FIFO_DEPTH) begin
                exp_q[rd_idx].push_back(word);
            end                                                   // full fifo drops it
            rd_idx++;
            db_o <= #1 word;
        end else if (rd_n_i && !rd_prev && rd_idx == `NUM_CH) begin
            conv_cnt++;                                           // last channel done
        end
        convst_prev = convst_i;
        rd_prev     = rd_n_i;
    end

endmodule

// ==== verification/tb_daq.sv ====
`timescale 1ns/1ns
`include "daq_settings.svh"

module tb_daq;

    localparam int SEED_INIT   = 32'h5ab1_5c2a;
    localparam int MAX_PERIOD  = 70000;       // longest phase period tried
    localparam int DIV_BASE    = 400;         // quiet gap between conversions
    localparam int DIV_SPAN    = 200;
    localparam int BUS_CYCLES  = 12;          // strobe plus recovery
    localparam int TEST_CYCLES = 3 * MAX_PERIOD + 40 * (DIV_BASE + DIV_SPAN)
                                 + 300 * BUS_CYCLES;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic               AD_CLK_40M;
    logic               rst_n;
    logic               mcu_cs_n, mcu_we_n, mcu_rd_n;
    logic [`ADDR_W-1:0] mcu_addr;
    logic [`DATA_W-1:0] mcu_wdata, mcu_rdata;
    logic               mcu_oe;
    logic [`DATA_W-1:0] adc_db;
    logic               adc_busy, adc_convst, adc_cs_n, adc_rd_n, adc_reset;
    logic               phase_in;
    int                 seed;
    int                 cycle_cnt = 0;

    daq_top dut_i (
        .AD_CLK_40M    (AD_CLK_40M),
        .rst_n_i       (rst_n),
        .mcu_cs_n_i    (mcu_cs_n),
        .mcu_we_n_i    (mcu_we_n),
        .mcu_rd_n_i    (mcu_rd_n),
        .mcu_addr_i    (mcu_addr),
        .mcu_data_i    (mcu_wdata),
        .mcu_data_o    (mcu_rdata),
        .mcu_data_oe_o (mcu_oe),
        .adc_db_i      (adc_db),
        .adc_busy_i    (adc_busy),
        .adc_convst_o  (adc_convst),
        .adc_cs_n_o    (adc_cs_n),
        .adc_rd_n_o    (adc_rd_n),
        .adc_reset_o   (adc_reset),
        .phase_in_i    (phase_in)
    );

    tb_adc_model #(.SEED(SEED_INIT)) adc_model (
        .clk_i    (AD_CLK_40M),
        .convst_i (adc_convst),
        .cs_n_i   (adc_cs_n),
        .rd_n_i   (adc_rd_n),
        .busy_o   (adc_busy),
        .db_o     (adc_db)
    );

    initial begin
        AD_CLK_40M = 1'b0;
        forever #5 AD_CLK_40M = ~AD_CLK_40M;   // 10 ns period
    end

    always @(posedge AD_CLK_40M) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d clock cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, expected %h, got %h", $time, what, exp, got);
            abort_run();
        end
    endtask

    task automatic tick(input int n);          // n edges plus the drive offset
        repeat (n) @(posedge AD_CLK_40M);
        #1;
    endtask

    task automatic bus_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
        mcu_addr  = addr;
        mcu_wdata = data;
        mcu_cs_n  = 1'b0;
        mcu_we_n  = 1'b0;
        tick(6);                               // master holds strobe 6 cycles
        mcu_cs_n = 1'b1;
        mcu_we_n = 1'b1;
        tick(4);
    endtask

    task automatic bus_read(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data);
        mcu_addr = addr;
        mcu_cs_n = 1'b0;
        mcu_rd_n = 1'b0;
        tick(6);
        check("oe during read", mcu_oe, 1);
        data     = mcu_rdata;                  // valid since the third cycle
        mcu_cs_n = 1'b1;
        mcu_rd_n = 1'b1;
        tick(4);
        check("oe after read", mcu_oe, 0);
    endtask

    function automatic logic [`ADDR_W-1:0] chan_addr(input int ch);
        case (ch)
            0:       return `ADDR_CH0_DATA;
            1:       return `ADDR_CH1_DATA;
            2:       return `ADDR_CH2_DATA;
            default: return `ADDR_CH3_DATA;
        endcase
    endfunction

    task automatic wait_conversions(input int n);
        int target;
        target = adc_model.conv_cnt + n;
        while (adc_model.conv_cnt < target) tick(1);
        tick(3);                               // last word lands in its fifo
    endtask

    task automatic arm_capture();
        bus_write(`ADDR_AD_ENABLE, 16'h0001);  // enable rising edge
        for (int c = 0; c < `NUM_CH; c++) adc_model.exp_q[c].delete();
    endtask

    task automatic drain_channel(input int ch);
        logic [`DATA_W-1:0] word;
        logic [`DATA_W-1:0] exp;
        while (adc_model.exp_q[ch].size() > 0) begin
            exp = adc_model.exp_q[ch].pop_front();
            bus_read(chan_addr(ch), word);
            check($sformatf("ch%0d word", ch), word, exp);
        end
        bus_read(chan_addr(ch), word);
        check($sformatf("ch%0d empty read", ch), word, 0);
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    initial begin
        logic [`DATA_W-1:0] rd_word;
        logic [`DATA_W-1:0] val;
        int                 period;
        seed      = SEED_INIT;
        rst_n     = 1'b0;
        mcu_cs_n  = 1'b1;
        mcu_we_n  = 1'b1;
        mcu_rd_n  = 1'b1;
        mcu_addr  = '0;
        mcu_wdata = '0;
        phase_in  = 1'b0;
        tick(5);
        rst_n = 1'b1;
        tick(2);
        check("convst after reset", adc_convst, 1);
        check("adc cs_n after reset", adc_cs_n, 1);
        check("adc rd_n after reset", adc_rd_n, 1);
        check("adc reset after reset", adc_reset, 0);
        check("oe after reset", mcu_oe, 0);

        // registers and adc reset pin
        bus_read(`ADDR_VERSION, rd_word);
        check("version", rd_word, `VERSION_WORD);
        repeat (4) begin
            val = $random(seed);
            bus_write(`ADDR_SAMPLE_DIV, val);
            bus_read(`ADDR_SAMPLE_DIV, rd_word);
            check("sample_div readback", rd_word, val);
        end
        for (int b = 1; b >= 0; b--) begin
            bus_write(`ADDR_AD_ENABLE, 16'(b));
            bus_read(`ADDR_AD_ENABLE, rd_word);
            check("ad_enable readback", rd_word, b);
            bus_write(`ADDR_AD_RESET, 16'(b));
            bus_read(`ADDR_AD_RESET, rd_word);
            check("ad_reset readback", rd_word, b);
            check("adc_reset pin", adc_reset, b);
        end

        // phase meter before any edge
        bus_read(`ADDR_STATUS, rd_word);
        check("detect_error before edges", rd_word[1], 1);
        bus_read(`ADDR_PHASE_L, rd_word);
        check("phase low before edges", rd_word, 0);
        bus_read(`ADDR_PHASE_H, rd_word);
        check("phase high before edges", rd_word, 0);
        period = 100 + $unsigned($random(seed)) % (MAX_PERIOD - 99);
        repeat (3) begin
            phase_in = 1'b1;
            tick(period / 2);
            phase_in = 1'b0;
            tick(period - period / 2);
        end
        bus_read(`ADDR_PHASE_L, rd_word);
        check("phase low half", rd_word, period & 32'hFFFF);
        bus_read(`ADDR_PHASE_H, rd_word);
        check("phase high half", rd_word, period >> 16);
        bus_read(`ADDR_STATUS, rd_word);
        check("detect_error after edges", rd_word[1], 0);

        // capture with reads in the gaps between conversions
        bus_write(`ADDR_SAMPLE_DIV, 16'(DIV_BASE + $unsigned($random(seed)) % DIV_SPAN));
        arm_capture();
        repeat (4) begin
            wait_conversions(1 + $unsigned($random(seed)) % 3);
            for (int c = 0; c < `NUM_CH; c++) drain_channel(c);
        end

        // let all fifos fill before draining
        do begin
            tick(50);
            bus_read(`ADDR_STATUS, rd_word);
        end while (rd_word[0] !== 1'b1);
        for (int c = 0; c < `NUM_CH; c++) begin
            check("expected words at full", adc_model.exp_q[c].size(), `FIFO_DEPTH);
            drain_channel(c);
        end

        // re-arm with words still queued
        bus_write(`ADDR_AD_ENABLE, 16'h0000);
        arm_capture();
        wait_conversions(2);
        bus_write(`ADDR_AD_ENABLE, 16'h0000);
        arm_capture();                         // old words must be gone
        wait_conversions(1);
        for (int c = 0; c < `NUM_CH; c++) drain_channel(c);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== daq.f ====
+incdir+design
design/daq_pkg.sv
design/acq_ctrl_if.sv
design/mcu_reg_bank.sv
design/phase_meter.sv
design/sample_trigger.sv
design/ad7606_seq.sv
design/sample_fifo_bank.sv
design/daq_top.sv
verification/tb_adc_model.sv
verification/tb_daq.sv

// ==== Makefile ====
# Verilator build and run of the DAQ testbench

VERILATOR ?= verilator
TOP       ?= tb_daq
FILELIST  ?= daq.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) design/daq_settings.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "result: passed"; \
	else \
		echo "result: failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
